// ==== src.f ====
+incdir+include
verilog/fir_pkg.sv
verilog/tap_shift_reg.sv
verilog/tap_multiplier.sv
verilog/product_adder.sv
verilog/output_scaler.sv
verilog/fir4_top.sv
bench/clk_gen.sv
bench/fir4_chk.sv
bench/fir4_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the FIR testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fir4_tb -f src.f -o fir4_sim
./obj_dir/fir4_sim | tee sim.log

if grep -qx "sim passed" sim.log; then
  echo "simulation result: PASS"
  exit 0
else
  echo "simulation result: FAIL"
  exit 1
fi

// ==== bench/fir4_tb.sv ====
`default_nettype none

`include "fir_macros.svh"

module fir4_tb import fir_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  logic    clk;
  logic    rst_n;
  logic    coef_valid_i;
  coef_t   coef_i;
  logic    sample_valid_i;
  sample_t sample_i;
  logic    y_valid_o;
  out_t    y_o;

  // testbench copy of both chains, tap 0 newest
  sample_t model_samples [`FIR_NTAPS];
  coef_t   model_coefs   [`FIR_NTAPS];
  out_t    expected_q [$];
  out_t    last_y;
  integer  seed = 32'h6180_4b5a;
  int      errors;
  int      checks;
  int      tests;
  int      got_count;
  bit      finished;

  clk_gen u_clk_gen (
    .clk  (clk),
    .rst_n(rst_n)
  );

  fir4_top fir4_top_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .coef_valid_i  (coef_valid_i),
    .coef_i        (coef_i),
    .sample_valid_i(sample_valid_i),
    .sample_i      (sample_i),
    .y_valid_o     (y_valid_o),
    .y_o           (y_o)
  );

  bind fir4_top fir4_chk u_chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .sample_valid_i(sample_valid_i),
    .y_valid_o     (y_valid_o),
    .y_o           (y_o)
  );

  function automatic out_t model_output();
    int acc;
    acc = 0;
    for (int k = 0; k < `FIR_NTAPS; k++) begin
      acc += int'(model_coefs[k]) * int'(model_samples[k]);
    end
    // add half an output step, then floor by the scale
    acc = (acc + (1 << (`FIR_ROUND_SHIFT - 1))) >>> `FIR_ROUND_SHIFT;
    if (acc > `FIR_OUT_MAX) begin
      acc = `FIR_OUT_MAX;
    end else if (acc < `FIR_OUT_MIN) begin
      acc = `FIR_OUT_MIN;
    end
    return out_t'(acc);
  endfunction

  task automatic compare_out(input string name, input out_t exp_y, input out_t act_y);
    checks++;
    if (act_y !== exp_y) begin
      errors++;
      $display("Mismatch in %s: expected %0d, actual %0d", name, exp_y, act_y);
    end
  endtask

  task automatic compare_count(input string name, input int exp_n, input int act_n);
    checks++;
    if (act_n != exp_n) begin
      errors++;
      $display("Mismatch in %s: expected %0d outputs, actual %0d", name, exp_n, act_n);
    end
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      sample_valid_i <= 1'b0;
      coef_valid_i   <= 1'b0;
    end
  endtask

  task automatic drive_sample(input sample_t s);
    @(posedge clk);
    sample_valid_i <= 1'b1;
    sample_i       <= s;
    for (int k = `FIR_NTAPS - 1; k > 0; k--) begin
      model_samples[k] = model_samples[k-1];
    end
    model_samples[0] = s;
    expected_q.push_back(model_output());
  endtask

  task automatic load_coefs(input coef_t c0, input coef_t c1, input coef_t c2, input coef_t c3);
    coef_t c [`FIR_NTAPS];
    c = '{c0, c1, c2, c3};
    // last tap goes in first so every value lands in its own tap
    for (int i = `FIR_NTAPS - 1; i >= 0; i--) begin
      @(posedge clk);
      coef_valid_i <= 1'b1;
      coef_i       <= c[i];
      for (int k = `FIR_NTAPS - 1; k > 0; k--) begin
        model_coefs[k] = model_coefs[k-1];
      end
      model_coefs[0] = c[i];
    end
    idle(1);
  endtask

  task automatic collect_outputs(input string name, input int n);
    int waited;
    got_count = 0;
    for (int i = 0; i < n; i++) begin
      waited = 0;
      @(negedge clk);
      while (!y_valid_o && waited < 20) begin
        @(negedge clk);
        waited++;
      end
      if (!y_valid_o) begin
        errors++;
        $display("%s: result %0d did not arrive within 20 cycles", name, i);
        expected_q.delete();
        break;
      end
      got_count++;
      last_y = y_o;
      compare_out(name, expected_q.pop_front(), y_o);
    end
    // stray pulses after the last result count as extra outputs
    repeat (5) begin
      @(negedge clk);
      if (y_valid_o) begin
        got_count++;
      end
    end
  endtask

  task automatic run_burst(input string name, input sample_t samples[$], input bit gapped);
    int gap;
    fork
      begin
        foreach (samples[i]) begin
          drive_sample(samples[i]);
          gap = gapped ? ($random(seed) & 3) : 0;
          if (gap > 0) begin
            idle(gap);
          end
        end
        idle(1);
      end
      collect_outputs(name, samples.size());
    join
    compare_count(name, samples.size(), got_count);
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    $display("%s finished with %0d errors", name, errors - err_before);
  endtask

  task automatic test_reset();
    sample_t samples [$];
    int err0;
    int quiet;
    err0 = errors;
    quiet = 0;
    for (int i = 0; i < 25 && quiet < 5; i++) begin
      @(negedge clk);
      if (y_valid_o) begin
        errors++;
        $display("test_reset: y_valid_o high with no sample sent");
      end
      if (rst_n) begin
        quiet++;
      end
    end
    if (quiet < 5) begin
      errors++;
      $display("test_reset: reset was never released");
    end
    // coefficients are still zero, so the output must be zero
    samples.push_back(sample_t'(93));
    run_burst("test_reset", samples, 1'b0);
    report_test("test_reset", err0);
  endtask

  task automatic test_impulse();
    sample_t samples [$];
    int err0;
    err0 = errors;
    load_coefs(64, -64, 32, 127);
    samples = '{0, 0, 0, 0, 64, 0, 0, 0};
    run_burst("test_impulse", samples, 1'b0);
    report_test("test_impulse", err0);
  endtask

  task automatic test_stream();
    sample_t samples [$];
    int err0;
    err0 = errors;
    load_coefs($random(seed), $random(seed), $random(seed), $random(seed));
    repeat (40) samples.push_back(sample_t'($random(seed)));
    run_burst("test_stream", samples, 1'b0);
    report_test("test_stream", err0);
  endtask

  task automatic test_saturation();
    sample_t samples [$];
    int err0;
    err0 = errors;
    load_coefs(-128, -128, -128, -128);
    samples = '{-128, -128, -128, -128};
    run_burst("test_saturation", samples, 1'b0);
    compare_out("test_saturation", `FIR_OUT_MAX, last_y);
    load_coefs(127, 127, 127, 127);
    samples = '{0, 0, 0, 0, -128, -128, -128, -128};
    run_burst("test_saturation", samples, 1'b0);
    compare_out("test_saturation", `FIR_OUT_MIN, last_y);
    report_test("test_saturation", err0);
  endtask

  task automatic test_rounding();
    sample_t samples [$];
    int err0;
    err0 = errors;
    // low six bits of the sum at 32 and at 31, on both signs
    load_coefs(1, 0, 0, 0);
    samples = '{96, 95, -96, -97};
    run_burst("test_rounding", samples, 1'b0);
    report_test("test_rounding", err0);
  endtask

  task automatic test_gapped();
    sample_t samples [$];
    int err0;
    err0 = errors;
    load_coefs($random(seed), $random(seed), $random(seed), $random(seed));
    repeat (16) samples.push_back(sample_t'($random(seed)));
    run_burst("test_gapped", samples, 1'b1);
    load_coefs($random(seed), $random(seed), $random(seed), $random(seed));
    samples.delete();
    repeat (16) samples.push_back(sample_t'($random(seed)));
    run_burst("test_gapped", samples, 1'b1);
    report_test("test_gapped", err0);
  endtask

  initial begin
    coef_valid_i   = 1'b0;
    coef_i         = '0;
    sample_valid_i = 1'b0;
    sample_i       = '0;
    for (int k = 0; k < `FIR_NTAPS; k++) begin
      model_samples[k] = '0;
      model_coefs[k]   = '0;
    end
    test_reset();
    test_impulse();
    test_stream();
    test_saturation();
    test_rounding();
    test_gapped();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    finished = 1'b1;
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // the run stopped early, e.g. on a failed assertion
  final begin
    if (!finished) begin
      $display("sim failed");
    end
  end

endmodule

`default_nettype wire

// ==== bench/fir4_chk.sv ====
`default_nettype none

`include "fir_macros.svh"

module fir4_chk import fir_pkg::*; (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic sample_valid_i,
  input wire logic y_valid_o,
  input wire out_t y_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // the strobe is sampled at E0, the output pulse is first sampled at the edge after E3
  valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
    y_valid_o == $past(sample_valid_i, `FIR_LATENCY + 1))
    else $error("y_valid_o does not follow the sample strobe by the pipeline latency");

  quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !y_valid_o)
    else $error("y_valid_o high while reset is asserted");

  // y_o only moves on the edge that raises y_valid_o
  output_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !y_valid_o |-> $stable(y_o))
    else $error("y_o changed while y_valid_o was low");

endmodule

`default_nettype wire

// ==== bench/clk_gen.sv ====
`default_nettype none

module clk_gen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset held low over the first five rising edges
  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== verilog/fir4_top.sv ====
`default_nettype none

`include "fir_macros.svh"

module fir4_top import fir_pkg::*; (
  input  wire logic    clk,
  input  wire logic    rst_n,
  input  wire logic    coef_valid_i,
  input  wire coef_t   coef_i,
  input  wire logic    sample_valid_i,
  input  wire sample_t sample_i,
  output logic         y_valid_o,
  output out_t         y_o
);

  sample_t sample_taps [`FIR_NTAPS];
  coef_t   coef_taps   [`FIR_NTAPS];
  prod_t   prods       [`FIR_NTAPS];
  logic    tap_valid   [`FIR_NTAPS];

  logic mult_valid_q;
  logic sum_valid;
  sum_t sum;

  // delay line, tap 0 is the newest sample
  tap_shift_reg #(
    .T(sample_t)
  ) u_sample_chain (
    .clk    (clk),
    .rst_n  (rst_n),
    .shift_i(sample_valid_i),
    .din_i  (sample_i),
    .taps_o (sample_taps)
  );

  tap_shift_reg #(
    .T(coef_t)
  ) u_coef_chain (
    .clk    (clk),
    .rst_n  (rst_n),
    .shift_i(coef_valid_i),
    .din_i  (coef_i),
    .taps_o (coef_taps)
  );

  // the taps settle on the strobe edge, products sample them one edge later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mult_valid_q <= 1'b0;
    end else begin
      mult_valid_q <= sample_valid_i;
    end
  end

  // even taps shift-and-add, odd taps native, so both get exercised
  for (genvar k = 0; k < `FIR_NTAPS; k++) begin : g_tap
    tap_multiplier #(
      .SHIFT_ADD((k % 2 == 0) ? 1 : 0)
    ) u_mult (
      .clk    (clk),
      .rst_n  (rst_n),
      .valid_i(mult_valid_q),
      .a_i    (sample_taps[k]),
      .b_i    (coef_taps[k]),
      .valid_o(tap_valid[k]),
      .prod_o (prods[k])
    );
  end

  // all taps run in lockstep, tap 0 speaks for the rest
  product_adder u_adder (
    .clk    (clk),
    .rst_n  (rst_n),
    .valid_i(tap_valid[0]),
    .prod_i (prods),
    .valid_o(sum_valid),
    .sum_o  (sum)
  );

  output_scaler u_scaler (
    .clk    (clk),
    .rst_n  (rst_n),
    .valid_i(sum_valid),
    .sum_i  (sum),
    .valid_o(y_valid_o),
    .y_o    (y_o)
  );

endmodule

`default_nettype wire

// ==== verilog/output_scaler.sv ====
`default_nettype none

`include "fir_macros.svh"

module output_scaler import fir_pkg::*; (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic valid_i,
  input  wire sum_t sum_i,
  output logic      valid_o,
  output out_t      y_o
);

  // half of one output LSB, gives round-half-up
  localparam int ROUND_HALF = 1 << (`FIR_ROUND_SHIFT - 1);

  sum_t rounded;
  sum_t shifted;
  out_t clamped;

  // no overflow here, the largest sum plus the constant still fits
  assign rounded = sum_i + sum_t'(ROUND_HALF);
  assign shifted = rounded >>> `FIR_ROUND_SHIFT;

  always_comb begin
    if (shifted > `FIR_OUT_MAX) begin
      clamped = out_t'(`FIR_OUT_MAX);
    end else if (shifted < `FIR_OUT_MIN) begin
      clamped = out_t'(`FIR_OUT_MIN);
    end else begin
      clamped = out_t'(shifted);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_o <= 1'b0;
      y_o     <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        y_o <= clamped;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/product_adder.sv ====
`default_nettype none

`include "fir_macros.svh"

module product_adder import fir_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  valid_i,
  input  wire prod_t prod_i [`FIR_NTAPS],
  output logic       valid_o,
  output sum_t       sum_o
);

  sum_t sum_d;

  // products are signed, the cast sign-extends to the sum width
  always_comb begin
    sum_d = '0;
    for (int k = 0; k < `FIR_NTAPS; k++) begin
      sum_d = sum_d + sum_t'(prod_i[k]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_o <= 1'b0;
      sum_o   <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        sum_o <= sum_d;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tap_multiplier.sv ====
`default_nettype none

module tap_multiplier import fir_pkg::*; #(
  parameter int SHIFT_ADD = 1
) (
  input  wire logic    clk,
  input  wire logic    rst_n,
  input  wire logic    valid_i,
  input  wire sample_t a_i,
  input  wire coef_t   b_i,
  output logic         valid_o,
  output prod_t        prod_o
);

  prod_t prod_d;

  generate
    if (SHIFT_ADD != 0) begin : g_shift_add
      logic [8:0]  a_ext;
      logic [8:0]  b_ext;
      logic [8:0]  a_mag;
      logic [8:0]  b_mag;
      logic [15:0] mag_prod;
      logic        neg;

      // 9-bit magnitudes so that -128 becomes +128 without wrapping
      assign a_ext = {a_i[7], a_i};
      assign b_ext = {b_i[7], b_i};
      assign a_mag = a_i[7] ? (~a_ext + 9'd1) : a_ext;
      assign b_mag = b_i[7] ? (~b_ext + 9'd1) : b_ext;

      assign neg = a_i[7] ^ b_i[7];

      // one shifted copy of a per set bit of b
      always_comb begin
        mag_prod = '0;
        for (int i = 0; i < 9; i++) begin
          if (b_mag[i]) begin
            mag_prod = mag_prod + (16'(a_mag) << i);
          end
        end
      end

      assign prod_d = neg ? prod_t'(~mag_prod + 16'd1) : prod_t'(mag_prod);
    end else begin : g_native
      assign prod_d = a_i * b_i;
    end
  endgenerate

  // same single stage in both modes keeps the pipeline latency fixed
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_o <= 1'b0;
      prod_o  <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        prod_o <= prod_d;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tap_shift_reg.sv ====
`default_nettype none

`include "fir_macros.svh"

module tap_shift_reg import fir_pkg::*; #(
  parameter type T = sample_t
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic shift_i,
  input  wire T     din_i,
  output T          taps_o [`FIR_NTAPS]
);

  T taps_q [`FIR_NTAPS];

  // tap 0 holds the newest entry, the last tap falls off the end
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `FIR_NTAPS; i++) begin
        taps_q[i] <= '0;
      end
    end else if (shift_i) begin
      taps_q[0] <= din_i;
      for (int i = 1; i < `FIR_NTAPS; i++) begin
        taps_q[i] <= taps_q[i-1];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `FIR_NTAPS; i++) begin
      taps_o[i] = taps_q[i];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fir_pkg.sv ====
`default_nettype none

package fir_pkg;

  // input sample, two's complement
  typedef logic signed [7:0] sample_t;

  // filter coefficient, two's complement
  typedef logic signed [7:0] coef_t;

  // full 8x8 signed product, -128 * -128 needs the top bit
  typedef logic signed [15:0] prod_t;

  // sum of four products, 4 * 16384 fits with room to spare
  typedef logic signed [17:0] sum_t;

  // rounded and saturated filter output
  typedef logic signed [9:0] out_t;

endpackage

`default_nettype wire

// ==== include/fir_macros.svh ====
`ifndef FIR_MACROS_SVH
`define FIR_MACROS_SVH

// number of filter taps, shared by both chains and the adder
`define FIR_NTAPS 4

// right shift applied to the tap sum before saturation
`define FIR_ROUND_SHIFT 6

// limits of the 10-bit signed output
`define FIR_OUT_MAX 511
`define FIR_OUT_MIN (-512)

// edges from the accepting sample strobe to y_valid_o
// taps at E0, products at E1, sum at E2, output at E3
`define FIR_LATENCY 3

`endif
